//--- Makefile
# Verilator lint, simulation and cleanup for the vmicro16 execute core

VERILATOR ?= verilator
TOP       ?= tb_vmicro16_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?=

SOURCES   := $(wildcard src/*.sv src/*.svh sim/*.sv sim/*.svh)
COMMON    := --timing --timescale 1ns/10ps -f $(FILELIST) --top-module $(TOP)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(COMMON) -Mdir $(BUILD_DIR) $(VFLAGS)

# Pass or fail is taken from the log, not from the exit code
sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_vmicro16_tasks.svh
// Register model, LCG operands, instruction encoders, compare tasks,
// pipelined driver and the directed tests for the execute core

// LCG operand source
function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        // Upper bits have the longer period
        return r[23:16];
endfunction

// Register format with op, rd, ra and sub-op fields
function automatic vmicro16_pkg::instr_t encode_rr(input logic [4:0] op, input int rd,
                                                   input int ra, input logic [4:0] sub);
        return {op, 3'(rd), 3'(ra), sub};
endfunction

// Immediate format with op, rd and imm8 fields
function automatic vmicro16_pkg::instr_t encode_movi(input int rd, input logic [7:0] imm);
        return {vmicro16_pkg::OP_MOVI, 3'(rd), imm};
endfunction

task automatic compare_data(input string name, input vmicro16_pkg::data_t got,
                            input vmicro16_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
endtask

task automatic compare_sel(input string name, input vmicro16_pkg::reg_sel_t got,
                           input vmicro16_pkg::reg_sel_t exp);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
endtask

task automatic compare_pulse(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
endtask

// Expected result from the ISA rules and model update
task automatic predict(input vmicro16_pkg::instr_t ins, output logic ev, output logic eb,
                       output vmicro16_pkg::reg_sel_t er, output vmicro16_pkg::data_t ed);
        logic [4:0]             op;
        logic [4:0]             sub;
        vmicro16_pkg::data_t    a;
        vmicro16_pkg::data_t    b;
        op  = ins[15:11];
        sub = ins[4:0];
        er  = ins[10:8];
        // a holds rd's value and b holds ra's value
        a   = model_regs[ins[10:8]];
        b   = model_regs[ins[7:5]];
        ev  = 1'b1;
        eb  = 1'b0;
        ed  = '0;
        if (op == vmicro16_pkg::OP_NOP) begin
                ev = 1'b0;
        end else if (op == vmicro16_pkg::OP_MOV) begin
                ed = b;
        end else if (op == vmicro16_pkg::OP_MOVI) begin
                // Negative bytes fill the upper byte with ones
                ed = ins[7] ? {8'hff, ins[7:0]} : {8'h00, ins[7:0]};
        end else if (op == vmicro16_pkg::OP_BIT && sub <= 5'd5) begin
                if (sub == 5'd0) ed = a | b;
                else if (sub == 5'd1) ed = a ^ b;
                else if (sub == 5'd2) ed = a & b;
                else if (sub == 5'd3) ed = ~b;
                // Amount of 16 or more leaves nothing
                else if (b > 16'd15) ed = '0;
                else if (sub == 5'd4) ed = a << b[3:0];
                else ed = a >> b[3:0];
        end else if (op == vmicro16_pkg::OP_ARITH_U && sub <= 5'd1) begin
                if (sub == 5'd0) ed = a + b;
                else ed = a - b;
        end else begin
                // Undefined opcode or sub-op leaves rd untouched
                ev = 1'b0;
                eb = 1'b1;
        end
        if (ev) model_regs[ins[10:8]] = ed;
endtask

// Drive one cycle and check the cycle issued LATENCY steps earlier
task automatic step(input logic valid, input vmicro16_pkg::instr_t ins);
        logic                   ev;
        logic                   eb;
        vmicro16_pkg::reg_sel_t er;
        vmicro16_pkg::data_t    ed;
        @(posedge clk);
        instr_valid_i <= valid;
        instr_i       <= ins;
        if (valid) begin
                predict(ins, ev, eb, er, ed);
        end else begin
                ev = 1'b0;
                eb = 1'b0;
                er = '0;
                ed = '0;
        end
        exp_valid_q.push_back(ev);
        exp_bad_q.push_back(eb);
        exp_reg_q.push_back(er);
        exp_data_q.push_back(ed);
        // Outputs are stable by the falling edge
        @(negedge clk);
        if (exp_valid_q.size() > LATENCY) begin
                ev = exp_valid_q.pop_front();
                eb = exp_bad_q.pop_front();
                er = exp_reg_q.pop_front();
                ed = exp_data_q.pop_front();
                compare_pulse("wb_valid_o", wb_valid_o, ev);
                compare_pulse("bad_instr_o", bad_instr_o, eb);
                if (ev) begin
                        compare_sel("wb_reg_o", wb_reg_o, er);
                        compare_data("wb_data_o", wb_data_o, ed);
                end
        end
endtask

// Idle cycles flush the pipeline
task automatic drain();
        int n;
        // Strobe stays low while a MOVI or an undefined opcode sits on the bus
        for (n = 0; n < LATENCY; n++) begin
                if (n % 2 == 0) begin
                        step(1'b0, encode_movi(n, 8'h5a));
                end else begin
                        step(1'b0, encode_rr(5'd1, n, n, 5'd3));
                end
        end
endtask

task automatic apply_reset();
        int n;
        reset         <= 1'b1;
        instr_valid_i <= 1'b0;
        for (n = 0; n < RESET_CYCLES; n++) begin
                @(posedge clk);
                if (n == RESET_CYCLES - 1) reset <= 1'b0;
                @(negedge clk);
                // No pulses while in reset
                compare_pulse("wb_valid_o", wb_valid_o, 1'b0);
                compare_pulse("bad_instr_o", bad_instr_o, 1'b0);
        end
        for (n = 0; n < `VM16_REG_COUNT; n++) model_regs[n] = '0;
        exp_valid_q.delete();
        exp_bad_q.delete();
        exp_reg_q.delete();
        exp_data_q.delete();
        // Pipeline is empty right after reset
        repeat (LATENCY) begin
                exp_valid_q.push_back(1'b0);
                exp_bad_q.push_back(1'b0);
                exp_reg_q.push_back('0);
                exp_data_q.push_back('0);
        end
endtask

task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
                $display("[%s] passed", name);
        end else begin
                tests_failed++;
                $display("[%s] failed with %0d errors", name, errors - err_start);
        end
endtask

// MOV each register into its neighbour after reset and expect zero
task automatic mov_after_reset();
        int err_start;
        int i;
        err_start = errors;
        apply_reset();
        for (i = 0; i < `VM16_REG_COUNT; i++) begin
                step(1'b1, encode_rr(vmicro16_pkg::OP_MOV, (i + 1) % `VM16_REG_COUNT, i, 5'd0));
        end
        drain();
        report_test("mov_after_reset", err_start);
endtask

// MOVI into every register across the sign boundary and read back through MOV
task automatic movi_sign_extend();
        logic [7:0] imms [`VM16_REG_COUNT];
        int         err_start;
        int         i;
        err_start = errors;
        imms = '{8'h00, 8'h01, 8'h7f, 8'h80, 8'hff, 8'h5a, 8'ha5, 8'hc3};
        for (i = 0; i < `VM16_REG_COUNT; i++) step(1'b1, encode_movi(i, imms[i]));
        // Copy from the next register so rd and ra hold different values
        for (i = 0; i < `VM16_REG_COUNT; i++) begin
                step(1'b1, encode_rr(vmicro16_pkg::OP_MOV, i, (i + 1) % `VM16_REG_COUNT, 5'd0));
        end
        drain();
        report_test("movi_sign_extend", err_start);
endtask

// All bit ops on LCG operands and then oversized shift amounts
task automatic bit_ops_random();
        logic [7:0] big_amts [3];
        logic [7:0] opnd;
        int         err_start;
        int         round;
        int         k;
        err_start = errors;
        big_amts = '{8'd16, 8'd31, 8'h80};
        for (round = 0; round < 3; round++) begin
                for (k = 0; k < 6; k++) begin
                        step(1'b1, encode_movi(2 * round, rand_byte()));
                        opnd = rand_byte();
                        // In-range amount for the shifts
                        if (k >= 4) opnd = {4'h0, opnd[3:0]};
                        step(1'b1, encode_movi(2 * round + 1, opnd));
                        step(1'b1, encode_rr(vmicro16_pkg::OP_BIT, 2 * round, 2 * round + 1,
                                             5'(k)));
                end
        end
        for (k = 0; k < 3; k++) begin
                step(1'b1, encode_movi(6, rand_byte() | 8'h01));
                step(1'b1, encode_movi(7, big_amts[k]));
                step(1'b1, encode_rr(vmicro16_pkg::OP_BIT, 6, 7, 5'd4));
                step(1'b1, encode_movi(6, rand_byte() | 8'h80));
                step(1'b1, encode_rr(vmicro16_pkg::OP_BIT, 6, 7, 5'd5));
        end
        drain();
        report_test("bit_ops_random", err_start);
endtask

// Wrap-around cases followed by a back-to-back dependent chain
task automatic arith_wrap_chain();
        int err_start;
        int n;
        err_start = errors;
        step(1'b1, encode_movi(1, 8'hff));
        step(1'b1, encode_movi(2, 8'h01));
        // 0xffff + 1 wraps to zero and 0 - 1 wraps back
        step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 1, 2, 5'd0));
        step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 1, 2, 5'd1));
        step(1'b1, encode_movi(3, 8'h80));
        step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 3, 3, 5'd0));
        step(1'b1, encode_movi(4, rand_byte()));
        step(1'b1, encode_movi(5, rand_byte()));
        // Each source is one of the last two results
        for (n = 0; n < 8; n++) begin
                step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 4, 5, 5'(n % 2)));
                step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 5, 4, 5'((n + 1) % 2)));
        end
        drain();
        report_test("arith_wrap_chain", err_start);
endtask

// Undefined opcodes and sub-ops and NOPs followed by register readback
task automatic undefined_ops();
        logic [4:0] bad_opc [5];
        int         err_start;
        int         i;
        err_start = errors;
        bad_opc = '{5'd1, 5'd2, 5'd5, 5'd8, 5'd31};
        for (i = 0; i < 5; i++) step(1'b1, encode_rr(bad_opc[i], i, i + 1, 5'(rand_byte())));
        step(1'b1, encode_rr(vmicro16_pkg::OP_BIT, 0, 1, 5'd6));
        step(1'b1, encode_rr(vmicro16_pkg::OP_BIT, 2, 3, 5'd31));
        step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 4, 5, 5'd2));
        step(1'b1, encode_rr(vmicro16_pkg::OP_ARITH_U, 6, 7, 5'd31));
        // NOP with junk in the other fields
        step(1'b1, 16'h0123);
        step(1'b1, 16'h07ff);
        for (i = 0; i < `VM16_REG_COUNT; i++) begin
                step(1'b1, encode_rr(vmicro16_pkg::OP_MOV, i, i, 5'd0));
        end
        drain();
        report_test("undefined_ops", err_start);
endtask

//--- sim/tb_vmicro16_core.sv
// Testbench top for the vmicro16 execute core: clock, reset, DUT,
// expected-result pipeline, timeout watchdog and summary
`timescale 1ns/10ps
`include "vmicro16_settings.svh"

module tb_vmicro16_core;

        localparam int CLK_PERIOD   = 40;
        localparam int RESET_CYCLES = 5;
        // Tests take about 150 cycles, limit leaves ample margin
        localparam int MAX_CYCLES   = 400;
        // Cycles from the driving edge to the writeback outputs
        localparam int LATENCY      = 2;

        // DUT signals
        logic                   clk;
        logic                   reset;
        logic                   instr_valid_i;
        vmicro16_pkg::instr_t   instr_i;
        logic                   wb_valid_o;
        vmicro16_pkg::reg_sel_t wb_reg_o;
        vmicro16_pkg::data_t    wb_data_o;
        logic                   bad_instr_o;

        // Register model in program order
        vmicro16_pkg::data_t    model_regs [`VM16_REG_COUNT];

        // Pending expectations, one entry per driven cycle, oldest first
        logic                   exp_valid_q [$];
        logic                   exp_bad_q [$];
        vmicro16_pkg::reg_sel_t exp_reg_q [$];
        vmicro16_pkg::data_t    exp_data_q [$];

        // Bookkeeping
        int                     errors;
        int                     checks;
        int                     tests_run;
        int                     tests_failed;
        int                     cycle_count;
        logic [31:0]            lcg_state;

        vmicro16_core i_vmicro16_core (
                .clk           (clk),
                .reset         (reset),
                .instr_valid_i (instr_valid_i),
                .instr_i       (instr_i),
                .wb_valid_o    (wb_valid_o),
                .wb_reg_o      (wb_reg_o),
                .wb_data_o     (wb_data_o),
                .bad_instr_o   (bad_instr_o)
        );

        // Free-running clock
        initial clk = 1'b0;
        always #(CLK_PERIOD / 2) clk = ~clk;

        // Watchdog on total run length
        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= MAX_CYCLES) begin
                        $display("TIMEOUT: run did not finish within %0d cycles", MAX_CYCLES);
                        $display("Finished with errors");
                        $finish;
                end
        end

        `include "tb_vmicro16_tasks.svh"

        initial begin
                // Inputs idle, reset held from time zero
                reset         = 1'b1;
                instr_valid_i = 1'b0;
                instr_i       = '0;
                errors        = 0;
                checks        = 0;
                tests_run     = 0;
                tests_failed  = 0;
                cycle_count   = 0;
                lcg_state     = 32'hbc1a_41b8;

                mov_after_reset();
                movi_sign_extend();
                bit_ops_random();
                arith_wrap_chain();
                undefined_ops();

                $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                         tests_run, tests_failed, checks, errors);
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

//--- src/vmicro16_alu.sv
// ALU and writeback register stage: merges decoder fields with
// register operands, drives result, destination and status pulses
`timescale 1ns/10ps

module vmicro16_alu (
        input  logic                   clk,
        input  logic                   reset,
        // From decoder
        input  vmicro16_pkg::alu_op_e  alu_op_i,
        input  vmicro16_pkg::reg_sel_t dest_i,
        input  vmicro16_pkg::data_t    imm_i,
        input  logic                   has_we_i,
        input  logic                   bad_i,
        input  logic                   valid_i,
        // From register file
        input  vmicro16_pkg::data_t    d1_i,
        input  vmicro16_pkg::data_t    d2_i,
        // Writeback
        output logic                   wb_valid_o,
        output vmicro16_pkg::reg_sel_t wb_reg_o,
        output vmicro16_pkg::data_t    wb_data_o,
        output logic                   bad_instr_o
);
        // Combinational result
        vmicro16_pkg::data_t result;

        // d1 is rd's value, d2 is ra's value
        always_comb begin
                result = '0;
                case (alu_op_i)
                        vmicro16_pkg::ALU_MOV:   result = d2_i;
                        vmicro16_pkg::ALU_MOVI:  result = imm_i;
                        vmicro16_pkg::ALU_OR:    result = d1_i | d2_i;
                        vmicro16_pkg::ALU_XOR:   result = d1_i ^ d2_i;
                        vmicro16_pkg::ALU_AND:   result = d1_i & d2_i;
                        vmicro16_pkg::ALU_NOT:   result = ~d2_i;
                        // Full 16-bit amount, 16 and above shifts everything out
                        vmicro16_pkg::ALU_LSHFT: result = d1_i << d2_i;
                        vmicro16_pkg::ALU_RSHFT: result = d1_i >> d2_i;
                        // Wraps mod 2^16
                        vmicro16_pkg::ALU_ADD:   result = d1_i + d2_i;
                        vmicro16_pkg::ALU_SUB:   result = d1_i - d2_i;
                        // NOP and BAD produce nothing
                        default:                 result = '0;
                endcase
        end

        // Status pulses, one cycle each
        always_ff @(posedge clk) begin
                if (reset) begin
                        wb_valid_o  <= 1'b0;
                        bad_instr_o <= 1'b0;
                end else begin
                        wb_valid_o  <= valid_i && has_we_i;
                        bad_instr_o <= valid_i && bad_i;
                end
        end

        // Destination and data only move on a valid instruction
        always_ff @(posedge clk) begin
                if (valid_i) begin
                        wb_reg_o  <= dest_i;
                        wb_data_o <= result;
                end
        end

endmodule

//--- src/vmicro16_core.sv
// vmicro16 execute core: decoder and register file in parallel,
// ALU writeback feeding the register file and the core outputs
`timescale 1ns/10ps

module vmicro16_core (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   instr_valid_i,
        input  vmicro16_pkg::instr_t   instr_i,
        output logic                   wb_valid_o,
        output vmicro16_pkg::reg_sel_t wb_reg_o,
        output vmicro16_pkg::data_t    wb_data_o,
        output logic                   bad_instr_o
);
        // Source selects straight from the instruction
        vmicro16_pkg::reg_sel_t rd_sel;
        vmicro16_pkg::reg_sel_t ra_sel;

        assign rd_sel = instr_i[10:8];
        assign ra_sel = instr_i[7:5];

        // Decoder to ALU
        vmicro16_pkg::alu_op_e  dec_alu_op;
        vmicro16_pkg::reg_sel_t dec_dest;
        vmicro16_pkg::data_t    dec_imm;
        logic                   dec_has_we;
        logic                   dec_bad;
        logic                   dec_valid;

        // Register file to ALU
        vmicro16_pkg::data_t    reg_rd1;
        vmicro16_pkg::data_t    reg_rd2;

        vmicro16_dec i_vmicro16_dec (
                .clk           (clk),
                .reset         (reset),
                .instr_valid_i (instr_valid_i),
                .instr_i       (instr_i),
                .alu_op_o      (dec_alu_op),
                .dest_o        (dec_dest),
                .imm_o         (dec_imm),
                .has_we_o      (dec_has_we),
                .bad_o         (dec_bad),
                .valid_o       (dec_valid)
        );

        // Write port fed back from the ALU writeback outputs
        vmicro16_regs i_vmicro16_regs (
                .clk   (clk),
                .reset (reset),
                .rs1_i (rd_sel),
                .rs2_i (ra_sel),
                .rd1_o (reg_rd1),
                .rd2_o (reg_rd2),
                .we_i  (wb_valid_o),
                .ws_i  (wb_reg_o),
                .wd_i  (wb_data_o)
        );

        vmicro16_alu i_vmicro16_alu (
                .clk         (clk),
                .reset       (reset),
                .alu_op_i    (dec_alu_op),
                .dest_i      (dec_dest),
                .imm_i       (dec_imm),
                .has_we_i    (dec_has_we),
                .bad_i       (dec_bad),
                .valid_i     (dec_valid),
                .d1_i        (reg_rd1),
                .d2_i        (reg_rd2),
                .wb_valid_o  (wb_valid_o),
                .wb_reg_o    (wb_reg_o),
                .wb_data_o   (wb_data_o),
                .bad_instr_o (bad_instr_o)
        );

endmodule

//--- src/vmicro16_dec.sv
// Registered instruction decoder: opcode and sub-op to ALU operation,
// destination select, sign-extended immediate and status flags
`timescale 1ns/10ps
`include "vmicro16_settings.svh"

module vmicro16_dec (
        input  logic                         clk,
        input  logic                         reset,
        input  logic                         instr_valid_i,
        input  vmicro16_pkg::instr_t         instr_i,
        output vmicro16_pkg::alu_op_e        alu_op_o,
        output vmicro16_pkg::reg_sel_t       dest_o,
        output vmicro16_pkg::data_t          imm_o,
        output logic                         has_we_o,
        output logic                         bad_o,
        output logic                         valid_o
);
        // Instruction fields
        vmicro16_pkg::opcode_e   opcode;
        vmicro16_pkg::bit_op_e   bit_op;
        vmicro16_pkg::arith_op_e arith_op;
        logic [7:0]              imm8;

        // Decoded, not yet registered
        vmicro16_pkg::alu_op_e   alu_op;
        logic                    has_we;

        assign opcode   = vmicro16_pkg::opcode_e'(instr_i[15:11]);
        // Same low five bits, read per opcode group
        assign bit_op   = vmicro16_pkg::bit_op_e'(instr_i[4:0]);
        assign arith_op = vmicro16_pkg::arith_op_e'(instr_i[4:0]);
        assign imm8     = instr_i[7:0];

        // Opcode and sub-op to internal ALU op
        always_comb begin
                alu_op = vmicro16_pkg::ALU_BAD;
                case (opcode)
                        vmicro16_pkg::OP_NOP:  alu_op = vmicro16_pkg::ALU_NOP;
                        vmicro16_pkg::OP_MOV:  alu_op = vmicro16_pkg::ALU_MOV;
                        vmicro16_pkg::OP_MOVI: alu_op = vmicro16_pkg::ALU_MOVI;
                        vmicro16_pkg::OP_BIT: begin
                                case (bit_op)
                                        vmicro16_pkg::BIT_OR:    alu_op = vmicro16_pkg::ALU_OR;
                                        vmicro16_pkg::BIT_XOR:   alu_op = vmicro16_pkg::ALU_XOR;
                                        vmicro16_pkg::BIT_AND:   alu_op = vmicro16_pkg::ALU_AND;
                                        vmicro16_pkg::BIT_NOT:   alu_op = vmicro16_pkg::ALU_NOT;
                                        vmicro16_pkg::BIT_LSHFT: alu_op = vmicro16_pkg::ALU_LSHFT;
                                        vmicro16_pkg::BIT_RSHFT: alu_op = vmicro16_pkg::ALU_RSHFT;
                                        // Undefined bit sub-op
                                        default:                 alu_op = vmicro16_pkg::ALU_BAD;
                                endcase
                        end
                        vmicro16_pkg::OP_ARITH_U: begin
                                case (arith_op)
                                        vmicro16_pkg::ARITH_ADD: alu_op = vmicro16_pkg::ALU_ADD;
                                        vmicro16_pkg::ARITH_SUB: alu_op = vmicro16_pkg::ALU_SUB;
                                        // Undefined arith sub-op
                                        default:                 alu_op = vmicro16_pkg::ALU_BAD;
                                endcase
                        end
                        // Undefined major opcode
                        default: alu_op = vmicro16_pkg::ALU_BAD;
                endcase
        end

        // Every defined op except NOP writes rd
        assign has_we = (alu_op != vmicro16_pkg::ALU_NOP) &&
                        (alu_op != vmicro16_pkg::ALU_BAD);

        // Control flags, qualified by the input strobe
        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_o  <= 1'b0;
                        bad_o    <= 1'b0;
                        has_we_o <= 1'b0;
                end else begin
                        valid_o  <= instr_valid_i;
                        bad_o    <= instr_valid_i && (alu_op == vmicro16_pkg::ALU_BAD);
                        has_we_o <= instr_valid_i && has_we;
                end
        end

        // Payload follows every cycle
        always_ff @(posedge clk) begin
                alu_op_o <= alu_op;
                // rd doubles as destination
                dest_o   <= instr_i[10:8];
                // Sign-extend imm8 to a full word
                imm_o    <= {{(`VM16_DATA_W-8){imm8[7]}}, imm8};
        end

endmodule

//--- src/vmicro16_pkg.sv
// Shared types for vmicro16: word types, ISA opcodes and sub-ops,
// internal ALU operation encoding
`include "vmicro16_settings.svh"

package vmicro16_pkg;

        // Word types
        typedef logic [`VM16_DATA_W-1:0]    data_t;
        typedef logic [`VM16_INSTR_W-1:0]   instr_t;
        typedef logic [`VM16_REG_SEL_W-1:0] reg_sel_t;

        // Major opcode in instr[15:11]
        // Values not listed here are undefined
        typedef enum logic [4:0] {
                OP_NOP     = 5'd0,
                OP_MOV     = 5'd3,
                OP_MOVI    = 5'd4,
                OP_BIT     = 5'd6,
                OP_ARITH_U = 5'd7
        } opcode_e;

        // Sub-op in instr[4:0] for OP_BIT
        typedef enum logic [4:0] {
                BIT_OR    = 5'd0,
                BIT_XOR   = 5'd1,
                BIT_AND   = 5'd2,
                BIT_NOT   = 5'd3,
                BIT_LSHFT = 5'd4,
                BIT_RSHFT = 5'd5
        } bit_op_e;

        // Sub-op in instr[4:0] for OP_ARITH_U
        typedef enum logic [4:0] {
                ARITH_ADD = 5'd0,
                ARITH_SUB = 5'd1
        } arith_op_e;

        // Flattened operation handed from decoder to ALU
        typedef enum logic [3:0] {
                ALU_NOP, ALU_MOV, ALU_MOVI,
                ALU_OR, ALU_XOR, ALU_AND, ALU_NOT,
                ALU_LSHFT, ALU_RSHFT,
                ALU_ADD, ALU_SUB,
                ALU_BAD
        } alu_op_e;

endpackage

//--- src/vmicro16_regs.sv
// Register file: eight words, two registered write-first read ports,
// one write port, cleared on reset
`timescale 1ns/10ps
`include "vmicro16_settings.svh"

module vmicro16_regs (
        input  logic                   clk,
        input  logic                   reset,
        // Read selects, rd and ra
        input  vmicro16_pkg::reg_sel_t rs1_i,
        input  vmicro16_pkg::reg_sel_t rs2_i,
        output vmicro16_pkg::data_t    rd1_o,
        output vmicro16_pkg::data_t    rd2_o,
        // Writeback port
        input  logic                   we_i,
        input  vmicro16_pkg::reg_sel_t ws_i,
        input  vmicro16_pkg::data_t    wd_i
);
        // Storage
        vmicro16_pkg::data_t    regs_q [`VM16_REG_COUNT];

        // Registered read data and the selects that produced it
        vmicro16_pkg::data_t    rd1_q;
        vmicro16_pkg::data_t    rd2_q;
        vmicro16_pkg::reg_sel_t rs1_q;
        vmicro16_pkg::reg_sel_t rs2_q;

        // Write port, all words cleared on reset
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < `VM16_REG_COUNT; i++) begin
                                regs_q[i] <= '0;
                        end
                end else if (we_i) begin
                        regs_q[ws_i] <= wd_i;
                end
        end

        // Read ports, write-first when the same word is written this edge
        always_ff @(posedge clk) begin
                rs1_q <= rs1_i;
                rs2_q <= rs2_i;
                if (we_i && (ws_i == rs1_i))
                        rd1_q <= wd_i;
                else
                        rd1_q <= regs_q[rs1_i];
                if (we_i && (ws_i == rs2_i))
                        rd2_q <= wd_i;
                else
                        rd2_q <= regs_q[rs2_i];
        end

        // The writeback of the instruction one ahead lands during this
        // read cycle, so forward it over the registered data
        assign rd1_o = (we_i && (ws_i == rs1_q)) ? wd_i : rd1_q;
        assign rd2_o = (we_i && (ws_i == rs2_q)) ? wd_i : rd2_q;

endmodule

//--- src/vmicro16_settings.svh
// Width and size macros for the vmicro16 execute datapath
`ifndef VMICRO16_SETTINGS_SVH
`define VMICRO16_SETTINGS_SVH

// Data word width
`define VM16_DATA_W 16

// Instruction word width
`define VM16_INSTR_W 16

// Number of general registers
`define VM16_REG_COUNT 8

// Register select width, log2 of the register count
`define VM16_REG_SEL_W 3

`endif

//--- vlog.f
+incdir+src
+incdir+sim
src/vmicro16_pkg.sv
src/vmicro16_dec.sv
src/vmicro16_regs.sv
src/vmicro16_alu.sv
src/vmicro16_core.sv
sim/tb_vmicro16_core.sv
